//--- Makefile
# Verilator build and run of the LSU replay testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_replay
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
source/lsu_conf_pkg.sv
source/lsu_types_pkg.sv
source/lsu_pipe_if.sv
source/ring_fifo.sv
source/lsu_replay_queue.sv
source/lsu_issue_arbiter.sv
source/lsu_replay_top.sv
testbench/tb_lsu_replay.sv

//--- source/lsu_conf_pkg.sv
// Width constants for LSU request fields, imported by the replay packages and modules

package lsu_conf_pkg;

    // ------------------------------
    // Request field widths
    // ------------------------------
    localparam int ID_W      = 6;   // Commit id
    localparam int PADDR_W   = 32;  // Physical address

    // One bit per store queue entry or miss unit entry
    localparam int HAZ_IDX_W = 8;

endpackage

//--- source/lsu_issue_arbiter.sv
// Registered issue stage that merges replays and fresh requests into the LSU pipeline

`timescale 1ns/1ps

module lsu_issue_arbiter (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    lsu_pipe_if.slave               rep_if,
    lsu_pipe_if.slave               iss_if,
    output logic                    o_pipe_valid,
    output lsu_types_pkg::lsu_req_t o_pipe_req,
    input  logic                    i_pipe_ready
);

    import lsu_types_pkg::*;

    arb_src_t r_src;
    lsu_req_t r_req;
    logic     w_accept;

    // Stage free or draining this cycle
    assign w_accept     = (r_src == SRC_EMPTY) || i_pipe_ready;
    assign rep_if.ready = w_accept;
    assign iss_if.ready = w_accept && !rep_if.valid;  // Replay wins

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_src <= SRC_EMPTY;
        end else if (w_accept) begin
            if (rep_if.valid) begin
                r_src <= SRC_REPLAY;
            end else if (iss_if.valid) begin
                r_src <= SRC_ISSUE;
            end else begin
                r_src <= SRC_EMPTY;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_accept && (rep_if.valid || iss_if.valid)) begin
            r_req <= rep_if.valid ? rep_if.payload : iss_if.payload;
        end
    end

    assign o_pipe_valid = (r_src != SRC_EMPTY);
    assign o_pipe_req   = r_req;

    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_pipe_valid && !i_pipe_ready) |=> (o_pipe_valid && $stable(o_pipe_req)));

endmodule

//--- source/lsu_pipe_if.sv
// Valid/ready handshake with a typed payload, connecting the LSU replay modules

`timescale 1ns/1ps

interface lsu_pipe_if #(
    parameter type T = logic
);

    logic valid;
    logic ready;
    T     payload;  // Held with valid until ready

    modport master (
        output valid,
        output payload,
        input  ready
    );

    modport slave (
        input  valid,
        input  payload,
        output ready
    );

endinterface

//--- source/lsu_replay_queue.sv
// Replay queue that holds hazarded LSU requests and reissues the head once its hazard resolves

`timescale 1ns/1ps

module lsu_replay_queue #(
    parameter int REPLAY_DEPTH = 6,
    parameter int TIMEOUT_W    = 4
) (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    lsu_pipe_if.slave                          haz_if,
    lsu_pipe_if.master                         rep_if,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_stq_resolve_mask,
    input  logic                               i_missu_full,
    input  logic                               i_missu_resolve_valid,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_missu_resolve_mask,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_missu_entry_valids,
    input  logic                               i_flush_valid,
    input  logic [lsu_conf_pkg::ID_W-1:0]      i_flush_id
);

    import lsu_conf_pkg::*;
    import lsu_types_pkg::*;

    localparam int PTR_W = (REPLAY_DEPTH > 1) ? $clog2(REPLAY_DEPTH) : 1;

    lsu_haz_t                  w_head;
    logic                      w_empty;
    logic                      w_full;
    logic                      w_push;
    logic                      w_pop;
    logic                      w_release;
    logic                      w_head_dead;
    logic                      w_timeout;
    logic                      w_flush_new;
    logic [REPLAY_DEPTH-1:0]   w_flush_hit;
    logic [PTR_W-1:0]          r_wr_ptr;
    logic [PTR_W-1:0]          r_rd_ptr;
    logic [REPLAY_DEPTH-1:0]   r_side_valid;
    logic [REPLAY_DEPTH-1:0]   r_side_dead;
    logic [ID_W-1:0]           r_side_id [REPLAY_DEPTH];
    logic [TIMEOUT_W-1:0]      r_wait;

    assign haz_if.ready = !w_full;
    assign w_push       = haz_if.valid && haz_if.ready;
    assign w_head_dead  = r_side_dead[r_rd_ptr];
    assign w_pop        = !w_empty && (w_head_dead || (rep_if.valid && rep_if.ready));

    ring_fifo #(
        .T     (lsu_haz_t),
        .DEPTH (REPLAY_DEPTH)
    ) haz_fifo_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (w_push),
        .i_data    (haz_if.payload),
        .i_pop     (w_pop),
        .o_data    (w_head),
        .o_empty   (w_empty),
        .o_full    (w_full)
    );

    // ------------------------------
    // Flush tracking
    // ------------------------------
    always_comb begin
        for (int i = 0; i < REPLAY_DEPTH; i++) begin
            w_flush_hit[i] = i_flush_valid && r_side_valid[i] && (r_side_id[i] >= i_flush_id);
        end
    end

    // Entry arriving together with a flush
    assign w_flush_new = i_flush_valid && (haz_if.payload.req.id >= i_flush_id);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_wr_ptr     <= '0;
            r_rd_ptr     <= '0;
            r_side_valid <= '0;
            r_side_dead  <= '0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= (r_wr_ptr == PTR_W'(REPLAY_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= (r_rd_ptr == PTR_W'(REPLAY_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
            end
            for (int i = 0; i < REPLAY_DEPTH; i++) begin
                if (w_push && (r_wr_ptr == PTR_W'(i))) begin
                    r_side_valid[i] <= 1'b1;
                    r_side_dead[i]  <= w_flush_new;
                end else if (w_pop && (r_rd_ptr == PTR_W'(i))) begin
                    r_side_valid[i] <= 1'b0;
                end else if (w_flush_hit[i]) begin
                    r_side_dead[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_side_id[r_wr_ptr] <= haz_if.payload.req.id;
        end
    end

    // ------------------------------
    // Head wait and release
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_wait <= '0;
        end else if (w_pop || w_empty) begin
            r_wait <= '0;
        end else if (!w_timeout) begin
            r_wait <= r_wait + 1'b1;  // Saturates
        end
    end

    assign w_timeout = &r_wait;

    always_comb begin
        w_release = 1'b0;
        if (!w_empty) begin
            if (w_timeout) begin
                w_release = 1'b1;
            end else begin
                case (w_head.haz_typ)
                    HAZ_STQ_NONFWD:     w_release = (w_head.haz_index & ~i_stq_resolve_mask) == '0;
                    HAZ_MISSU_FULL:     w_release = !i_missu_full;
                    HAZ_MISSU_ASSIGNED: w_release =
                        (i_missu_resolve_valid && (i_missu_resolve_mask == w_head.haz_index)) ||
                        ((w_head.haz_index & i_missu_entry_valids) == '0);
                    HAZ_L1D_CONFLICT:   w_release = 1'b1;
                    default:            w_release = 1'b0;
                endcase
            end
        end
    end

    assign rep_if.valid   = w_release && !w_head_dead;
    assign rep_if.payload = w_head.req;

    a_no_haz_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        haz_if.valid |-> !w_full);
    a_no_haz_none: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !w_empty |-> (w_head.haz_typ != HAZ_NONE));

endmodule

//--- source/lsu_replay_top.sv
// Top of the LSU replay subsystem, joining the replay queue and issue arbiter behind plain ports

`timescale 1ns/1ps

module lsu_replay_top #(
    parameter int REPLAY_DEPTH = 6,
    parameter int TIMEOUT_W    = 4
) (
    input  logic                               i_clk,
    input  logic                               i_reset_n,
    input  logic                               i_issue_valid,
    input  logic [lsu_conf_pkg::ID_W-1:0]      i_issue_id,
    input  logic [31:0]                        i_issue_inst,
    input  logic [lsu_conf_pkg::PADDR_W-1:0]   i_issue_paddr,
    input  logic                               i_issue_is_store,
    output logic                               o_issue_ready,
    input  logic                               i_haz_valid,
    input  logic [lsu_conf_pkg::ID_W-1:0]      i_haz_id,
    input  logic [31:0]                        i_haz_inst,
    input  logic [lsu_conf_pkg::PADDR_W-1:0]   i_haz_paddr,
    input  logic                               i_haz_is_store,
    input  lsu_types_pkg::haz_typ_t            i_haz_typ,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_haz_index,
    output logic                               o_replay_full,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_stq_resolve_mask,
    input  logic                               i_missu_full,
    input  logic                               i_missu_resolve_valid,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_missu_resolve_mask,
    input  logic [lsu_conf_pkg::HAZ_IDX_W-1:0] i_missu_entry_valids,
    input  logic                               i_flush_valid,
    input  logic [lsu_conf_pkg::ID_W-1:0]      i_flush_id,
    output logic                               o_pipe_valid,
    output logic [lsu_conf_pkg::ID_W-1:0]      o_pipe_id,
    output logic [31:0]                        o_pipe_inst,
    output logic [lsu_conf_pkg::PADDR_W-1:0]   o_pipe_paddr,
    output logic                               o_pipe_is_store,
    input  logic                               i_pipe_ready
);

    import lsu_types_pkg::*;

    lsu_pipe_if #(.T(lsu_haz_t)) haz_if ();
    lsu_pipe_if #(.T(lsu_req_t)) rep_if ();
    lsu_pipe_if #(.T(lsu_req_t)) iss_if ();

    lsu_req_t w_pipe_req;

    // ------------------------------
    // Port to interface mapping
    // ------------------------------
    assign haz_if.valid                  = i_haz_valid;
    assign haz_if.payload.req.id         = i_haz_id;
    assign haz_if.payload.req.inst       = i_haz_inst;
    assign haz_if.payload.req.paddr      = i_haz_paddr;
    assign haz_if.payload.req.is_store   = i_haz_is_store;
    assign haz_if.payload.haz_typ        = i_haz_typ;
    assign haz_if.payload.haz_index      = i_haz_index;
    assign o_replay_full                 = !haz_if.ready;

    assign iss_if.valid            = i_issue_valid;
    assign iss_if.payload.id       = i_issue_id;
    assign iss_if.payload.inst     = i_issue_inst;
    assign iss_if.payload.paddr    = i_issue_paddr;
    assign iss_if.payload.is_store = i_issue_is_store;
    assign o_issue_ready           = iss_if.ready;

    assign o_pipe_id       = w_pipe_req.id;
    assign o_pipe_inst     = w_pipe_req.inst;
    assign o_pipe_paddr    = w_pipe_req.paddr;
    assign o_pipe_is_store = w_pipe_req.is_store;

    lsu_replay_queue #(
        .REPLAY_DEPTH (REPLAY_DEPTH),
        .TIMEOUT_W    (TIMEOUT_W)
    ) lsu_replay_queue_i (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .haz_if                (haz_if.slave),
        .rep_if                (rep_if.master),
        .i_stq_resolve_mask    (i_stq_resolve_mask),
        .i_missu_full          (i_missu_full),
        .i_missu_resolve_valid (i_missu_resolve_valid),
        .i_missu_resolve_mask  (i_missu_resolve_mask),
        .i_missu_entry_valids  (i_missu_entry_valids),
        .i_flush_valid         (i_flush_valid),
        .i_flush_id            (i_flush_id)
    );

    lsu_issue_arbiter lsu_issue_arbiter_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .rep_if       (rep_if.slave),
        .iss_if       (iss_if.slave),
        .o_pipe_valid (o_pipe_valid),
        .o_pipe_req   (w_pipe_req),
        .i_pipe_ready (i_pipe_ready)
    );

endmodule

//--- source/lsu_types_pkg.sv
// Request, hazard and arbiter types shared by the LSU replay modules and the testbench

package lsu_types_pkg;

    // ------------------------------
    // Hazard types from the pipeline
    // ------------------------------
    typedef enum logic [2:0] {
        HAZ_NONE           = 3'd0,
        HAZ_STQ_NONFWD     = 3'd1,  // Older store data not ready
        HAZ_MISSU_FULL     = 3'd2,
        HAZ_MISSU_ASSIGNED = 3'd3,  // Waiting on a miss entry
        HAZ_L1D_CONFLICT   = 3'd4
    } haz_typ_t;

    // ------------------------------
    // Payloads
    // ------------------------------
    typedef struct packed {
        logic [lsu_conf_pkg::ID_W-1:0]    id;
        logic [31:0]                      inst;
        logic [lsu_conf_pkg::PADDR_W-1:0] paddr;
        logic                             is_store;
    } lsu_req_t;

    // Request returned by the pipeline with its hazard
    typedef struct packed {
        lsu_req_t                           req;
        haz_typ_t                           haz_typ;
        logic [lsu_conf_pkg::HAZ_IDX_W-1:0] haz_index;
    } lsu_haz_t;

    // Content of the issue output stage
    typedef enum logic [1:0] {
        SRC_EMPTY  = 2'd0,
        SRC_ISSUE  = 2'd1,
        SRC_REPLAY = 2'd2
    } arb_src_t;

endpackage

//--- source/ring_fifo.sv
// Circular FIFO with count, used by the replay queue to hold hazarded requests

`timescale 1ns/1ps

module ring_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_push,
    input  T     i_data,
    input  logic i_pop,
    output T     o_data,
    output logic o_empty,
    output logic o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 r_mem [DEPTH];
    logic [PTR_W-1:0] r_head;
    logic [PTR_W-1:0] r_tail;
    logic [CNT_W-1:0] r_count;

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            r_mem[r_tail] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            r_head  <= '0;
            r_tail  <= '0;
            r_count <= '0;
        end else begin
            if (i_push) begin
                r_tail <= (r_tail == PTR_W'(DEPTH - 1)) ? '0 : r_tail + 1'b1;
            end
            if (i_pop) begin
                r_head <= (r_head == PTR_W'(DEPTH - 1)) ? '0 : r_head + 1'b1;
            end
            if (i_push && !i_pop) begin
                r_count <= r_count + 1'b1;
            end else if (!i_push && i_pop) begin
                r_count <= r_count - 1'b1;
            end
        end
    end

    assign o_data  = r_mem[r_head];  // Oldest entry, no read latency
    assign o_empty = (r_count == '0);
    assign o_full  = (r_count == CNT_W'(DEPTH));

    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_push && o_full));
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_pop && o_empty));

endmodule

//--- testbench/tb_lsu_replay.sv
// Testbench for the LSU replay subsystem, drives issues and hazards and checks the pipe output

`timescale 1ns/1ps

module tb_lsu_replay;

    import lsu_types_pkg::*;

    localparam int DEPTH     = 6;
    localparam int TIMEOUT_W = 4;
    localparam int AGE_MAX   = 2**TIMEOUT_W + 2;  // Below this age no timeout release is possible

    logic        i_clk = 1'b0;
    logic        i_reset_n;
    logic        i_issue_valid, i_issue_is_store, o_issue_ready;
    logic [5:0]  i_issue_id;
    logic [31:0] i_issue_inst, i_issue_paddr;
    logic        i_haz_valid, i_haz_is_store, o_replay_full;
    logic [5:0]  i_haz_id;
    logic [31:0] i_haz_inst, i_haz_paddr;
    haz_typ_t    i_haz_typ;
    logic [7:0]  i_haz_index, i_stq_resolve_mask, i_missu_resolve_mask, i_missu_entry_valids;
    logic        i_missu_full, i_missu_resolve_valid, i_flush_valid;
    logic [5:0]  i_flush_id;
    logic        o_pipe_valid, o_pipe_is_store;
    logic [5:0]  o_pipe_id;
    logic [31:0] o_pipe_inst, o_pipe_paddr;
    logic        i_pipe_ready = 1'b0;

    // Scoreboard, indexed by commit id
    haz_typ_t    hz_typ [0:63];
    logic [7:0]  hz_idx [0:63];
    logic [31:0] hz_inst [0:63];
    logic [31:0] hz_paddr [0:63];
    logic        hz_store [0:63];
    int          enq_cyc [0:63];
    logic        in_queue [0:63];
    logic        dead [0:63];

    logic        rand_ready = 1'b0;
    logic        prev_accept = 1'b0;
    logic        new_out, release_ok, prev_mfull, prev_rv;
    logic [7:0]  prev_stq, prev_rm, prev_ev;
    logic [5:0]  last_iss_id;
    logic [31:0] last_iss_inst;
    logic [31:0] last_iss_paddr;
    logic        last_iss_store;
    logic [5:0]  out_q [$];
    int          cyc = 0;
    int          errors = 0;
    int          check_errs = 0;
    int          tests = 0;
    int          failed = 0;

    lsu_replay_top #(.REPLAY_DEPTH(DEPTH), .TIMEOUT_W(TIMEOUT_W)) lsu_replay_top_i (.*);

    always #20 i_clk = ~i_clk;

    // ------------------------------
    // Pipeline model
    // ------------------------------
    always @(posedge i_clk) begin
        cyc            <= cyc + 1;
        prev_accept    <= !o_pipe_valid || i_pipe_ready;
        prev_stq       <= i_stq_resolve_mask;
        prev_mfull     <= i_missu_full;
        prev_rv        <= i_missu_resolve_valid;
        prev_rm        <= i_missu_resolve_mask;
        prev_ev        <= i_missu_entry_valids;
        last_iss_id    <= i_issue_id;
        last_iss_inst  <= i_issue_inst;
        last_iss_paddr <= i_issue_paddr;
        last_iss_store <= i_issue_is_store;
        i_pipe_ready <= rand_ready ? 1'($urandom % 2) : 1'b1;
        if (o_pipe_valid && i_pipe_ready) begin
            out_q.push_back(o_pipe_id);
        end
    end

    assign new_out = o_pipe_valid && prev_accept;  // Stage freshly loaded

    // Hazard rule as seen one cycle before the replay shows
    always_comb begin
        case (hz_typ[o_pipe_id])
            HAZ_STQ_NONFWD:     release_ok = (hz_idx[o_pipe_id] & ~prev_stq) == 8'h00;
            HAZ_MISSU_FULL:     release_ok = !prev_mfull;
            HAZ_MISSU_ASSIGNED: release_ok = (prev_rv && prev_rm == hz_idx[o_pipe_id]) ||
                                             ((hz_idx[o_pipe_id] & prev_ev) == 8'h00);
            HAZ_L1D_CONFLICT:   release_ok = 1'b1;
            default:            release_ok = 1'b0;
        endcase
        if (cyc - enq_cyc[o_pipe_id] >= AGE_MAX) begin
            release_ok = 1'b1;
        end
    end

    // ------------------------------
    // Concurrent checks
    // ------------------------------
    a_issue_pass: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_issue_valid && o_issue_ready) |=> (o_pipe_valid && o_pipe_id == last_iss_id &&
        o_pipe_inst == last_iss_inst && o_pipe_paddr == last_iss_paddr &&
        o_pipe_is_store == last_iss_store))
        else begin
            errors++;
            $display("FAIL o_pipe_id/inst/paddr/is_store got %h/%h/%h/%h exp %h/%h/%h/%h",
                     $sampled(o_pipe_id), $sampled(o_pipe_inst),
                     $sampled(o_pipe_paddr), $sampled(o_pipe_is_store),
                     $sampled(last_iss_id), $sampled(last_iss_inst),
                     $sampled(last_iss_paddr), $sampled(last_iss_store));
        end
    a_replay_payload: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (new_out && in_queue[o_pipe_id]) |-> (o_pipe_inst == hz_inst[o_pipe_id] &&
        o_pipe_paddr == hz_paddr[o_pipe_id] && o_pipe_is_store == hz_store[o_pipe_id]))
        else begin
            errors++;
            $display("FAIL o_pipe_inst/paddr/is_store got %h/%h/%h exp %h/%h/%h",
                     $sampled(o_pipe_inst), $sampled(o_pipe_paddr),
                     $sampled(o_pipe_is_store), hz_inst[$sampled(o_pipe_id)],
                     hz_paddr[$sampled(o_pipe_id)], hz_store[$sampled(o_pipe_id)]);
        end
    a_release_rule: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (new_out && in_queue[o_pipe_id]) |-> release_ok)
        else begin
            errors++;
            $display("Replay of id %0d left the queue before its hazard resolved",
                     $sampled(o_pipe_id));
        end
    a_no_flushed: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        new_out |-> !dead[o_pipe_id])
        else begin
            errors++;
            $display("Flushed id %0d reached the pipe", $sampled(o_pipe_id));
        end
    a_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_pipe_valid && !i_pipe_ready) |=> (o_pipe_valid && $stable(o_pipe_id) &&
        $stable(o_pipe_inst) && $stable(o_pipe_paddr) && $stable(o_pipe_is_store)))
        else begin
            errors++;
            $display("FAIL o_pipe_id changed to %h under back-pressure", o_pipe_id);
        end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic send_haz(input logic [5:0] id, input haz_typ_t typ, input logic [7:0] idx);
        @(posedge i_clk);
        hz_typ[id]   = typ;
        hz_idx[id]   = idx;
        hz_inst[id]  = $urandom;
        hz_paddr[id] = $urandom;
        hz_store[id] = 1'($urandom % 2);
        enq_cyc[id]  = cyc;
        in_queue[id] = 1'b1;
        i_haz_valid    <= 1'b1;
        i_haz_id       <= id;
        i_haz_inst     <= hz_inst[id];
        i_haz_paddr    <= hz_paddr[id];
        i_haz_is_store <= hz_store[id];
        i_haz_typ      <= typ;
        i_haz_index    <= idx;
    endtask

    task automatic haz_idle();
        @(posedge i_clk);
        i_haz_valid <= 1'b0;
    endtask

    task automatic issue_wait();
        int n;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!o_issue_ready && n < 50);
        i_issue_valid <= 1'b0;
        if (!o_issue_ready) begin
            check_errs++;
            $display("Fresh issue was never accepted");
        end
    endtask

    task automatic send_issue(input logic [5:0] id);
        @(posedge i_clk);
        i_issue_valid    <= 1'b1;
        i_issue_id       <= id;
        i_issue_inst     <= $urandom;
        i_issue_paddr    <= $urandom;
        i_issue_is_store <= 1'($urandom % 2);
        issue_wait();
    endtask

    task automatic wait_id(input logic [5:0] id, input int max);
        int  n;
        bit  seen;
        n = 0;
        seen = 0;
        while (!seen && n < max) begin
            @(posedge i_clk);
            n++;
            if (new_out && o_pipe_id == id) seen = 1;
        end
        if (!seen) begin
            check_errs++;
            $display("Replay id %0d did not reach the pipe within %0d cycles", id, max);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge i_clk);
    endtask

    task automatic flush(input logic [5:0] fid);
        @(posedge i_clk);
        for (int i = 0; i < 64; i++) begin
            if (in_queue[i] && i >= fid) dead[i] = 1'b1;
        end
        i_flush_valid <= 1'b1;
        i_flush_id    <= fid;
        @(posedge i_clk);
        i_flush_valid <= 1'b0;
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors + check_errs > err_before) begin
            failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    initial begin
        int e;
        int start;
        int n;
        void'($urandom(46513));
        for (int i = 0; i < 64; i++) begin
            hz_typ[i] = HAZ_NONE;
            hz_idx[i] = '0;
            hz_inst[i] = '0;
            hz_paddr[i] = '0;
            hz_store[i] = 1'b0;
            enq_cyc[i] = 0;
            in_queue[i] = 1'b0;
            dead[i] = 1'b0;
        end
        i_reset_n = 1'b0;
        {i_issue_valid, i_issue_is_store, i_issue_id, i_issue_inst, i_issue_paddr} = '0;
        {i_haz_valid, i_haz_is_store, i_haz_id, i_haz_inst, i_haz_paddr} = '0;
        i_haz_typ = HAZ_NONE;
        i_haz_index = '0;
        {i_stq_resolve_mask, i_missu_resolve_mask, i_missu_entry_valids} = '0;
        {i_missu_full, i_missu_resolve_valid, i_flush_valid, i_flush_id} = '0;
        repeat (10) @(posedge i_clk);
        i_reset_n <= 1'b1;
        idle(2);

        // Fresh issues only
        e = errors + check_errs;
        for (int k = 0; k < 8; k++) send_issue(6'($urandom % 32));
        idle(3);
        end_test("fresh issue", e);

        // L1D conflict against a competing issue
        e = errors + check_errs;
        start = out_q.size();
        send_haz(6'd40, HAZ_L1D_CONFLICT, 8'h00);
        @(posedge i_clk);
        i_haz_valid   <= 1'b0;
        i_issue_valid <= 1'b1;
        i_issue_id    <= 6'd5;
        issue_wait();
        idle(3);
        assert (out_q.size() >= start + 2 && out_q[start] == 6'd40 && out_q[start+1] == 6'd5)
        else begin
            check_errs++;
            $display("Replay did not win over the pending issue");
        end
        end_test("l1d conflict", e);

        // Miss unit full, then timeout
        e = errors + check_errs;
        i_missu_full <= 1'b1;
        send_haz(6'd41, HAZ_MISSU_FULL, 8'h00);
        haz_idle();
        idle(8);
        i_missu_full <= 1'b0;
        wait_id(6'd41, 20);
        i_missu_full <= 1'b1;
        send_haz(6'd42, HAZ_MISSU_FULL, 8'h00);
        haz_idle();
        wait_id(6'd42, 40);
        i_missu_full <= 1'b0;
        end_test("miss unit full", e);

        // Store queue and miss assigned
        e = errors + check_errs;
        i_stq_resolve_mask <= 8'h04;
        send_haz(6'd43, HAZ_STQ_NONFWD, 8'h0c);
        haz_idle();
        idle(5);
        i_stq_resolve_mask <= 8'h0c;
        wait_id(6'd43, 20);
        i_stq_resolve_mask   <= 8'h00;
        i_missu_entry_valids <= 8'hff;
        send_haz(6'd44, HAZ_MISSU_ASSIGNED, 8'h02);
        haz_idle();
        idle(5);
        i_missu_resolve_valid <= 1'b1;
        i_missu_resolve_mask  <= 8'h02;
        @(posedge i_clk);
        i_missu_resolve_valid <= 1'b0;
        wait_id(6'd44, 20);
        send_haz(6'd45, HAZ_MISSU_ASSIGNED, 8'h10);
        haz_idle();
        idle(5);
        i_missu_entry_valids <= 8'hef;
        wait_id(6'd45, 20);
        i_missu_entry_valids <= 8'h00;
        end_test("stq and miss assigned", e);

        // Flush of younger entries
        e = errors + check_errs;
        send_haz(6'd46, HAZ_STQ_NONFWD, 8'h01);
        send_haz(6'd47, HAZ_STQ_NONFWD, 8'h01);
        send_haz(6'd50, HAZ_STQ_NONFWD, 8'h01);
        send_haz(6'd51, HAZ_STQ_NONFWD, 8'h01);
        haz_idle();
        flush(6'd50);
        i_stq_resolve_mask <= 8'h01;
        wait_id(6'd46, 30);
        wait_id(6'd47, 30);
        idle(10);
        i_stq_resolve_mask <= 8'h00;
        end_test("flush", e);

        // Full queue and back-pressure
        e = errors + check_errs;
        start = out_q.size();
        for (int k = 52; k < 52 + DEPTH; k++) send_haz(6'(k), HAZ_STQ_NONFWD, 8'h01);
        haz_idle();
        @(posedge i_clk);
        assert (o_replay_full)
        else begin
            check_errs++;
            $display("FAIL o_replay_full got %h exp %h", o_replay_full, 1'b1);
        end
        rand_ready = 1'b1;
        for (int k = 10; k < 14; k++) send_issue(6'(k));
        i_stq_resolve_mask <= 8'h01;
        n = 0;
        while (out_q.size() - start < DEPTH + 4 && n < 300) begin
            @(posedge i_clk);
            n++;
        end
        idle(5);
        assert (out_q.size() - start == DEPTH + 4)
        else begin
            check_errs++;
            $display("FAIL pipe transfer count got %h exp %h", out_q.size() - start, DEPTH + 4);
        end
        rand_ready = 1'b0;
        i_stq_resolve_mask <= 8'h00;
        end_test("full and back-pressure", e);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors + check_errs);
        if (failed == 0 && errors + check_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
